/* logic/cpu6502_defs.svh */
`ifndef CPU6502_DEFS_SVH
`define CPU6502_DEFS_SVH

// Highest control flag index
`define NUMFLAGS 40

`define DATA_W 8

// Program counter after reset
`define PC_RESET 16'h0200

// LDA opcodes per addressing mode
`define OP_LDA_ZPG 8'hA5
`define OP_LDA_ABS 8'hAD
`define OP_LDA_ABSX 8'hBD

`endif

/* logic/ctrlPkg.sv */
`default_nettype none
`include "cpu6502_defs.svh"

package ctrlPkg;

    typedef enum logic [5:0] {
        setAdhLow,
        setAdlToData,
        loadAbl,
        loadAbh,
        pcInc,
        setAdlToPcl,
        setAdhToPch,
        setDbToData,
        setInputBToDb,
        setSbToDb,
        setAdlToAlu,
        setAdhToSb,
        setInputAToSb,
        setSbToX,
        setSbToAlu,
        aluAdd
    } flagIdxE;

    typedef logic [`NUMFLAGS:0] ctrlFlagsT;

    // Timing states, IDLE parks the counter
    typedef enum logic [3:0] {
        A0 = 4'd0,
        A1 = 4'd1,
        A2 = 4'd2,
        A3 = 4'd3,
        A4 = 4'd4,
        A5 = 4'd5,
        IDLE = 4'hF
    } tStateE;

    typedef enum logic [1:0] {ZPG, ABS, ABSX, NONE} addrModeE;

endpackage

`default_nettype wire

/* logic/busPkg.sv */
`default_nettype none
`include "cpu6502_defs.svh"

package busPkg;

    // Effective address as seen on the pins
    typedef struct packed {
        logic [`DATA_W-1:0] abh;
        logic [`DATA_W-1:0] abl;
    } addrBusT;

    // X register load request
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] value;
    } xLoadT;

endpackage

`default_nettype wire

/* logic/addrModeFlags.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module zeroPageFlags
    import ctrlPkg::*;
(
    input  tStateE    state,
    output ctrlFlagsT flags
);

    always_comb begin
        flags = '0;
        case (state)
            A0: begin
                // Page zero, operand is the low byte
                flags[setAdhLow] = 1'b1;
                flags[setAdlToData] = 1'b1;
                flags[loadAbl] = 1'b1;
                flags[loadAbh] = 1'b1;
                flags[pcInc] = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

module absoluteFlags
    import ctrlPkg::*;
(
    input  tStateE    state,
    output ctrlFlagsT flags
);

    always_comb begin
        flags = '0;
        case (state)
            A0: begin
                // Address bus follows PC for the operand fetch
                flags[pcInc] = 1'b1;
                flags[setAdlToPcl] = 1'b1;
                flags[setAdhToPch] = 1'b1;
                flags[loadAbl] = 1'b1;
                flags[loadAbh] = 1'b1;
                // Low operand parked in the ALU
                flags[setDbToData] = 1'b1;
                flags[setInputBToDb] = 1'b1;
            end
            A1: begin
                flags[pcInc] = 1'b1;
                flags[setAdlToAlu] = 1'b1;
                flags[loadAbl] = 1'b1;
                // High operand via DB and SB
                flags[setDbToData] = 1'b1;
                flags[setSbToDb] = 1'b1;
                flags[setAdhToSb] = 1'b1;
                flags[loadAbh] = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

module absoluteXFlags
    import ctrlPkg::*;
(
    input  tStateE    state,
    output ctrlFlagsT flags
);

    always_comb begin
        flags = '0;
        case (state)
            A0: begin
                flags[pcInc] = 1'b1;
                flags[setAdlToPcl] = 1'b1;
                flags[setAdhToPch] = 1'b1;
                flags[loadAbl] = 1'b1;
                flags[loadAbh] = 1'b1;
                // Low operand plus X
                flags[aluAdd] = 1'b1;
                flags[setDbToData] = 1'b1;
                flags[setInputBToDb] = 1'b1;
                flags[setSbToX] = 1'b1;
                flags[setInputAToSb] = 1'b1;
            end
            A1: begin
                flags[pcInc] = 1'b1;
                flags[setAdlToAlu] = 1'b1;
                flags[loadAbl] = 1'b1;
                // High operand plus carry, A side sees an idle SB
                flags[aluAdd] = 1'b1;
                flags[setDbToData] = 1'b1;
                flags[setInputBToDb] = 1'b1;
                flags[setInputAToSb] = 1'b1;
            end
            A2: begin
                flags[setSbToAlu] = 1'b1;
                flags[setAdhToSb] = 1'b1;
                flags[loadAbh] = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/timingControl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module timingControl
    import ctrlPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               opValid,
    input  logic [`DATA_W-1:0] opCode,
    output ctrlFlagsT          flags,
    output logic               busy,
    output logic               addrValid
);

    tStateE    state;
    tStateE    lastState;
    addrModeE  mode;
    addrModeE  opMode;
    ctrlFlagsT zpgFlags;
    ctrlFlagsT absFlags;
    ctrlFlagsT absXFlags;

    zeroPageFlags uZpg (.state(state), .flags(zpgFlags));
    absoluteFlags uAbs (.state(state), .flags(absFlags));
    absoluteXFlags uAbsX (.state(state), .flags(absXFlags));

    always_comb begin
        case (opCode)
            `OP_LDA_ZPG:  opMode = ZPG;
            `OP_LDA_ABS:  opMode = ABS;
            `OP_LDA_ABSX: opMode = ABSX;
            default:      opMode = NONE;
        endcase
    end

    always_comb begin
        case (mode)
            ABS:     lastState = A1;
            ABSX:    lastState = A2;
            default: lastState = A0;
        endcase
    end

    always_comb begin
        case (mode)
            ZPG:     flags = zpgFlags;
            ABS:     flags = absFlags;
            ABSX:    flags = absXFlags;
            default: flags = '0;
        endcase
    end

    assign busy = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            mode <= NONE;
            addrValid <= 1'b0;
        end else begin
            addrValid <= 1'b0;
            if (state == IDLE) begin
                // Unsupported opcodes stay idle
                if (opValid) begin
                    mode <= opMode;
                    if (opMode != NONE) state <= A0;
                end
            end else if (state == lastState) begin
                state <= IDLE;
                addrValid <= 1'b1;
            end else begin
                state <= tStateE'(state + 4'd1);
            end
        end
    end

    validAfterBusy: assert property (@(posedge clk) disable iff (!rstN)
        addrValid |-> !busy)
        else $error("addrValid raised during a busy sequence");

    stateInRange: assert property (@(posedge clk) disable iff (!rstN)
        busy |-> (state <= lastState))
        else $error("timing state ran past the last state of its mode");

endmodule

`default_nettype wire

/* logic/addressPath.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module addressPath
    import ctrlPkg::*;
    import busPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlFlagsT            flags,
    input  logic [`DATA_W-1:0]   dataIn,
    input  xLoadT                xLoad,
    output addrBusT              addrBus,
    output logic [2*`DATA_W-1:0] pc
);

    logic [`DATA_W-1:0] xReg;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluRes;
    logic [`DATA_W-1:0] aEff;
    logic [`DATA_W-1:0] bEff;
    logic [`DATA_W-1:0] db;
    logic [`DATA_W-1:0] sb;
    logic [`DATA_W-1:0] adl;
    logic [`DATA_W-1:0] adh;
    logic [`DATA_W:0]   sum;
    logic               carry;

    // Undriven internal buses read as zero
    assign db = flags[setDbToData] ? dataIn : '0;

    always_comb begin
        if (flags[setSbToX]) sb = xReg;
        else if (flags[setSbToAlu]) sb = aluRes;
        else if (flags[setSbToDb]) sb = db;
        else sb = '0;
    end

    always_comb begin
        if (flags[setAdlToData]) adl = dataIn;
        else if (flags[setAdlToAlu]) adl = aluRes;
        else if (flags[setAdlToPcl]) adl = pc[`DATA_W-1:0];
        else adl = '0;
    end

    always_comb begin
        if (flags[setAdhLow]) adh = '0;
        else if (flags[setAdhToSb]) adh = sb;
        else if (flags[setAdhToPch]) adh = pc[2*`DATA_W-1:`DATA_W];
        else adh = '0;
    end

    // ALU sees this cycle's bus values when its inputs are loaded
    assign aEff = flags[setInputAToSb] ? sb : aluA;
    assign bEff = flags[setInputBToDb] ? db : aluB;
    assign sum = {1'b0, aEff} + {1'b0, bEff} + {{`DATA_W{1'b0}}, carry};

    always_ff @(posedge clk) begin
        if (!rstN) pc <= `PC_RESET;
        else if (flags[pcInc]) pc <= pc + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            addrBus <= '0;
        end else begin
            if (flags[loadAbl]) addrBus.abl <= adl;
            if (flags[loadAbh]) addrBus.abh <= adh;
        end
    end

    always_ff @(posedge clk) begin
        if (xLoad.valid) xReg <= xLoad.value;
        if (flags[setInputAToSb]) aluA <= sb;
        if (flags[setInputBToDb]) aluB <= db;
        // Without an add the ALU passes B through
        if (flags[aluAdd]) aluRes <= sum[`DATA_W-1:0];
        else if (flags[setInputBToDb]) aluRes <= bEff;
    end

    // Carry only survives between back-to-back adds
    always_ff @(posedge clk) begin
        if (!rstN) carry <= 1'b0;
        else if (flags[aluAdd]) carry <= sum[`DATA_W];
        else carry <= 1'b0;
    end

    ablHasSource: assert property (@(posedge clk) disable iff (!rstN)
        flags[loadAbl] |->
            (flags[setAdlToData] || flags[setAdlToAlu] || flags[setAdlToPcl]))
        else $error("ABL loaded with no ADL source selected");

endmodule

`default_nettype wire

/* logic/addrGenTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module addrGenTop
    import ctrlPkg::*;
    import busPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 opValid,
    input  logic [`DATA_W-1:0]   opCode,
    input  logic [`DATA_W-1:0]   dataIn,
    input  xLoadT                xLoad,
    output addrBusT              addrBus,
    output logic                 addrValid,
    output logic [2*`DATA_W-1:0] pc,
    output logic                 busy
);

    ctrlFlagsT flags;

    timingControl uCtrl (
        .clk(clk),
        .rstN(rstN),
        .opValid(opValid),
        .opCode(opCode),
        .flags(flags),
        .busy(busy),
        .addrValid(addrValid)
    );

    addressPath uPath (
        .clk(clk),
        .rstN(rstN),
        .flags(flags),
        .dataIn(dataIn),
        .xLoad(xLoad),
        .addrBus(addrBus),
        .pc(pc)
    );

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/addrGenTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu6502_defs.svh"

module addrGenTb
    import busPkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_WAIT = 8;
    localparam int IDLE_WATCH = 4;

    // One line of the vector file
    typedef struct packed {
        logic [7:0]  op;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  x;
        logic [15:0] addr;
        logic [3:0]  opt;
    } vectorT;

    logic                 clk;
    logic                 rstN;
    logic                 opValid;
    logic [`DATA_W-1:0]   opCode;
    logic [`DATA_W-1:0]   dataIn;
    xLoadT                xLoad;
    addrBusT              addrBus;
    logic                 addrValid;
    logic [2*`DATA_W-1:0] pc;
    logic                 busy;

    vectorT vectors[$];
    integer seed;
    int     errorCount = 0;
    int     checkCount = 0;
    int     testCount = 0;
    bit     vectorsLoaded = 1'b0;

    clockGen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) uClk (.clk(clk), .rstN(rstN));

    addrGenTop dut (
        .clk(clk),
        .rstN(rstN),
        .opValid(opValid),
        .opCode(opCode),
        .dataIn(dataIn),
        .xLoad(xLoad),
        .addrBus(addrBus),
        .addrValid(addrValid),
        .pc(pc),
        .busy(busy)
    );

    // Cycles from opValid to addrValid or zero when unsupported
    function automatic int cyclesFor(input logic [7:0] op);
        case (op)
            `OP_LDA_ZPG:  return 1;
            `OP_LDA_ABS:  return 2;
            `OP_LDA_ABSX: return 3;
            default:      return 0;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0d ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) $display("%s: ok", name);
        else $display("%s: %0d mismatches", name, errorCount - errorsBefore);
    endtask

    task automatic readVectors();
        integer         fd;
        integer         n;
        reg [8*160-1:0] line;
        logic [15:0]    op;
        logic [15:0]    lo;
        logic [15:0]    hi;
        logic [15:0]    x;
        logic [15:0]    addr;
        logic [15:0]    opt;
        fd = $fopen("bench/addrGen_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/addrGen_vectors.txt");
        end else begin
            // Comment lines fail the scan and are skipped
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h", op, lo, hi, x, addr, opt);
                if (n == 6) begin
                    vectors.push_back({op[7:0], lo[7:0], hi[7:0], x[7:0],
                                       addr, opt[3:0]});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runVector(input vectorT v);
        logic [15:0] expAddr;
        logic [15:0] pcStart;
        addrBusT     busStart;
        logic [31:0] randWord;
        int          latency;
        int          cycles;
        latency = cyclesFor(v.op);
        expAddr = v.addr;
        if (v.opt == 4'd1) begin
            randWord = $random(seed);
            v.x = randWord[7:0];
            expAddr = {v.hi, v.lo} + {8'h00, v.x};
        end
        xLoad.valid = 1'b1;
        xLoad.value = v.x;
        @(negedge clk);
        xLoad = '0;
        pcStart = pc;
        busStart = addrBus;
        opValid = 1'b1;
        opCode = v.op;
        dataIn = v.lo;
        @(negedge clk);
        // Stray strobe during A0 must be ignored
        opValid = (v.opt == 4'd2);
        opCode = (v.opt == 4'd2) ? `OP_LDA_ABSX : 8'h00;
        if (latency == 0) begin
            repeat (IDLE_WATCH) begin
                checkValue("busy", busy, 0);
                checkValue("addrValid", addrValid, 0);
                @(negedge clk);
            end
            checkValue("pc", pc, pcStart);
            checkValue("addrBus", addrBus, busStart);
        end else begin
            cycles = 0;
            while (!addrValid && cycles < MAX_WAIT) begin
                checkValue("busy while stepping", busy, 1);
                @(negedge clk);
                cycles++;
                opValid = 1'b0;
                if (cycles == 1) dataIn = v.hi;
            end
            if (!addrValid) begin
                errorCount++;
                $display("No addrValid pulse within %0d cycles of opValid", MAX_WAIT);
            end else begin
                checkValue("latency", cycles, latency);
                checkValue("addrBus", addrBus, expAddr);
                checkValue("pc", pc, pcStart + ((latency == 1) ? 16'd1 : 16'd2));
                checkValue("busy", busy, 0);
            end
            dataIn = '0;
            @(negedge clk);
            checkValue("addrValid after pulse", addrValid, 0);
        end
    endtask

    initial begin
        int errorsBefore;
        seed = 32'h155f5bd5;
        opValid = 1'b0;
        opCode = '0;
        dataIn = '0;
        xLoad = '0;
        readVectors();
        vectorsLoaded = 1'b1;
        if (vectors.size() == 0) begin
            $display("No test vectors could be read from bench/addrGen_vectors.txt");
            $display("Test failed");
            $finish;
        end else begin
            wait (rstN === 1'b1);
            @(negedge clk);
            errorsBefore = errorCount;
            checkValue("pc", pc, `PC_RESET);
            checkValue("addrBus", addrBus, 0);
            checkValue("busy", busy, 0);
            checkValue("addrValid", addrValid, 0);
            reportTest("reset state", errorsBefore);
            for (int i = 0; i < vectors.size(); i++) begin
                errorsBefore = errorCount;
                runVector(vectors[i]);
                reportTest($sformatf("vector %0d op %02h", i, vectors[i].op), errorsBefore);
            end
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     testCount, checkCount, errorCount);
            if (errorCount == 0) $display("Test completed successfully");
            else $display("Test failed");
            $finish;
        end
    end

    // Ten cycles per vector plus slack for reset
    initial begin
        int limitCycles;
        wait (vectorsLoaded);
        limitCycles = vectors.size() * 10 + 100;
        #(limitCycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/ctrlPkg.sv
logic/busPkg.sv
logic/addrModeFlags.sv
logic/timingControl.sv
logic/addressPath.sv
logic/addrGenTop.sv
bench/clockGen.sv
bench/addrGenTb.sv

/* bench/addrGen_vectors.txt */
// columns in hex: opcode operandLow operandHigh xValue expectedAddress opt
// opt 0 plain, 1 X drawn from the seeded random source, 2 stray opValid while busy
a5 34 00 00 0034 0
a5 ff 12 00 00ff 0
ad 00 10 00 1000 0
ad cd ab 00 abcd 0
bd 00 20 05 2005 0
bd f0 20 20 2110 0
bd ff ff 01 0000 0
bd 80 7f 80 8000 0
ad 55 44 00 4455 2
bd fe 01 03 0201 2
a5 77 00 00 0077 2
02 11 22 00 0000 0
ff 00 00 00 0000 0
bd 10 30 00 0000 1
bd f8 c3 00 0000 1
bd 99 ff 00 0000 1
a5 00 00 00 0000 0
